// ==== project.f ====
rtl/sys_defs_pkg.sv
rtl/inst_buffer.sv
rtl/dispatch.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rob.sv
rtl/cpu.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module cpu_tb -o cpu_tb_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/cpu_tb_sim > sim.log 2>&1
cat sim.log
grep -qx ">>> PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb
    import sys_defs_pkg::*;
();

    localparam int n       = 2;
    localparam int ib_sz   = 8;
    localparam int rob_sz  = 8;
    localparam int timeout = 200;  // cycles per wait
    localparam int max_seq = 128;

    logic                       clock;
    logic                       reset;
    inst_packet_t [7:0]         in_insts;
    logic [3:0]                 num_input;
    cdb_packet_t                cdb_in;
    commit_packet_t [n-1:0]     committed_insts;
    logic [$clog2(ib_sz+1)-1:0] ib_open;

    cpu #(.n(n), .ib_sz(ib_sz), .rob_sz(rob_sz)) dut (
        .clock           (clock),
        .reset           (reset),
        .in_insts        (in_insts),
        .num_input       (num_input),
        .cdb_in          (cdb_in),
        .committed_insts (committed_insts),
        .ib_open         (ib_open)
    );

    always #10 clock = ~clock;  // 20 ns

    ////////////////////////////////////////////////////////////////////////////
    // reference model of renaming
    ////////////////////////////////////////////////////////////////////////////

    phys_reg_idx_t mmap [arch_reg_sz];  // model map table
    phys_reg_idx_t free_q [$];          // model free list with head first
    reg_idx_t      exp_dest  [max_seq];  // per instruction in program order
    phys_reg_idx_t exp_t     [max_seq];
    phys_reg_idx_t exp_t1    [max_seq];
    phys_reg_idx_t exp_t2    [max_seq];
    phys_reg_idx_t exp_t_old [max_seq];
    phys_reg_idx_t act_t_old [max_seq];  // as seen at commit
    inst_packet_t  stage [$];            // next group to send
    int            pred_count;           // instructions predicted
    int            dis_count;            // seen leaving dispatch
    int            commit_count;
    int            errors;
    string         cur_test;
    logic [31:0]   lcg_state;

    function automatic reg_idx_t rand_reg();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[18:16];  // upper bits since low ones cycle fast
    endfunction

    task automatic report_mismatch(string what, int expected, int actual);
        errors++;
        $display("** Error %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("%s failed: %s", cur_test, what);
    endtask

    task automatic model_reset();
        free_q.delete();
        for (int i = 0; i < arch_reg_sz; i++) begin
            mmap[i] = phys_reg_idx_t'(i);  // identity after reset
        end
        for (int i = arch_reg_sz; i < phys_reg_sz; i++) begin
            free_q.push_back(phys_reg_idx_t'(i));
        end
    endtask

    // rename in program order and stage the packet
    task automatic queue_inst(reg_idx_t dest, reg_idx_t r1, reg_idx_t r2);
        inst_packet_t p;
        p.valid        = 1'b1;
        p.dest_reg_idx = dest;
        p.reg1         = r1;
        p.reg2         = r2;
        stage.push_back(p);
        exp_dest[pred_count]  = dest;
        exp_t1[pred_count]    = mmap[r1];
        exp_t2[pred_count]    = mmap[r2];
        exp_t_old[pred_count] = mmap[dest];
        exp_t[pred_count]     = free_q.pop_front();
        // insts retire in order so each t_old rejoins the fifo in that order
        free_q.push_back(exp_t_old[pred_count]);
        mmap[dest] = exp_t[pred_count];
        pred_count++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_staged();
        inst_packet_t [7:0] grp;
        int                 k;
        int                 cycles;
        k   = stage.size();
        grp = '0;
        for (int i = 0; i < k; i++) begin
            grp[i] = stage[i];
        end
        stage.delete();
        cycles = 0;
        @(negedge clock);
        while (int'(ib_open) < k) begin  // never offer more than is open
            if (cycles == timeout) begin
                report_failure("instruction buffer never opened room");
                return;
            end
            cycles++;
            @(negedge clock);
        end
        @(posedge clock);
        in_insts  <= grp;
        num_input <= 4'(k);
        @(posedge clock);
        num_input <= '0;
    endtask

    // broadcast a tag once its inst sits in the rob
    task automatic complete_inst(int seq);
        cdb_packet_t c;
        int          cycles;
        cycles = 0;
        @(posedge clock);
        while (dis_count <= seq) begin
            if (cycles == timeout) begin
                report_failure("instruction never dispatched");
                return;
            end
            cycles++;
            @(posedge clock);
        end
        c.valid = 1'b1;
        c.t     = exp_t[seq];
        cdb_in <= c;
        @(posedge clock);
        cdb_in <= '0;
    endtask

    task automatic wait_commits(int target);
        int cycles;
        cycles = 0;
        while (commit_count < target) begin
            if (cycles == timeout) begin
                report_failure("commits stopped short");
                return;
            end
            cycles++;
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitors sampled mid-cycle before the coming edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            for (int i = 0; i < n; i++) begin
                if (i < int'(dut.num_dis)) begin
                    if (dis_count >= pred_count) begin
                        report_failure("dispatch of an instruction never sent");
                    end else begin
                        if (dut.dis_insts[i].t != exp_t[dis_count])
                            report_mismatch("dispatch t", int'(exp_t[dis_count]),
                                            int'(dut.dis_insts[i].t));
                        if (dut.dis_insts[i].t1 != exp_t1[dis_count])
                            report_mismatch("dispatch t1", int'(exp_t1[dis_count]),
                                            int'(dut.dis_insts[i].t1));
                        if (dut.dis_insts[i].t2 != exp_t2[dis_count])
                            report_mismatch("dispatch t2", int'(exp_t2[dis_count]),
                                            int'(dut.dis_insts[i].t2));
                        if (dut.dis_insts[i].t_old != exp_t_old[dis_count])
                            report_mismatch("dispatch t_old", int'(exp_t_old[dis_count]),
                                            int'(dut.dis_insts[i].t_old));
                    end
                    dis_count++;
                end
            end
        end
    end

    always @(negedge clock) begin
        if (!reset) begin
            for (int i = 0; i < n; i++) begin
                if (committed_insts[i].valid) begin
                    if (commit_count >= dis_count) begin
                        report_failure("commit of an instruction never dispatched");
                    end else begin
                        if (committed_insts[i].dest_reg_idx != exp_dest[commit_count])
                            report_mismatch("commit dest", int'(exp_dest[commit_count]),
                                            int'(committed_insts[i].dest_reg_idx));
                        if (committed_insts[i].t != exp_t[commit_count])
                            report_mismatch("commit t", int'(exp_t[commit_count]),
                                            int'(committed_insts[i].t));
                        if (committed_insts[i].t_old != exp_t_old[commit_count])
                            report_mismatch("commit t_old", int'(exp_t_old[commit_count]),
                                            int'(committed_insts[i].t_old));
                        act_t_old[commit_count] = committed_insts[i].t_old;
                    end
                    commit_count++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        cur_test = "reset_state";
        @(negedge clock);
        if (int'(ib_open) != ib_sz) report_mismatch("ib_open", ib_sz, int'(ib_open));
        repeat (6) begin
            for (int i = 0; i < n; i++) begin
                if (committed_insts[i].valid) report_failure("commit valid with nothing sent");
            end
            @(negedge clock);
        end
    endtask

    task automatic test_in_order();
        int base;
        cur_test = "in_order";
        base     = pred_count;
        queue_inst(3'd1, 3'd0, 3'd0);
        queue_inst(3'd2, 3'd1, 3'd1);  // reads lane 0 result
        send_staged();
        queue_inst(3'd3, 3'd2, 3'd1);
        queue_inst(3'd1, 3'd3, 3'd2);  // rewrites r1
        send_staged();
        for (int i = 0; i < 4; i++) begin
            complete_inst(base + i);
        end
        wait_commits(pred_count);
    endtask

    task automatic test_out_of_order();
        int base;
        cur_test = "out_of_order";
        base     = pred_count;
        queue_inst(3'd4, 3'd1, 3'd2);
        queue_inst(3'd5, 3'd4, 3'd3);
        send_staged();
        queue_inst(3'd6, 3'd5, 3'd4);
        queue_inst(3'd7, 3'd6, 3'd0);
        send_staged();
        complete_inst(base + 3);  // youngest first
        complete_inst(base + 2);
        complete_inst(base + 1);
        repeat (4) @(posedge clock);
        if (commit_count != base) report_mismatch("commits before oldest done", base, commit_count);
        complete_inst(base);
        wait_commits(pred_count);
    endtask

    task automatic test_same_dest();
        int base;
        cur_test = "same_dest";
        base     = pred_count;
        queue_inst(3'd5, 3'd1, 3'd2);
        queue_inst(3'd5, 3'd5, 3'd5);  // same group and same dest
        send_staged();
        complete_inst(base);
        complete_inst(base + 1);
        wait_commits(pred_count);
        if (act_t_old[base+1] != exp_t[base])
            report_mismatch("lane 1 t_old", int'(exp_t[base]), int'(act_t_old[base+1]));
    endtask

    task automatic test_back_pressure();
        int base;
        int cycles;
        cur_test = "back_pressure";
        base     = pred_count;
        for (int i = 0; i < 16; i++) begin
            queue_inst(reg_idx_t'(i % 8), reg_idx_t'((i + 1) % 8), reg_idx_t'((i + 3) % 8));
            if (i % 2 == 1) send_staged();
        end
        cycles = 0;
        @(negedge clock);
        while (ib_open != '0) begin  // buffer fills once rob and free list are full
            if (cycles == timeout) begin
                report_failure("instruction buffer never filled");
                break;
            end
            cycles++;
            @(negedge clock);
        end
        repeat (3) @(posedge clock);
        if (commit_count != base) report_mismatch("commits with none complete", base, commit_count);
        for (int i = 0; i < 16; i++) begin
            complete_inst(base + i);
        end
        wait_commits(pred_count);
    endtask

    task automatic test_recycling();
        int       b;
        reg_idx_t coin;
        cur_test = "recycling";
        for (int g = 0; g < 20; g++) begin
            b = pred_count;
            queue_inst(rand_reg(), rand_reg(), rand_reg());
            queue_inst(rand_reg(), rand_reg(), rand_reg());
            send_staged();
            coin = rand_reg();
            if (coin[0]) begin  // swap completion order now and then
                complete_inst(b + 1);
                complete_inst(b);
            end else begin
                complete_inst(b);
                complete_inst(b + 1);
            end
        end
        wait_commits(pred_count);
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        in_insts     = '0;
        num_input    = '0;
        cdb_in       = '0;
        lcg_state    = 32'hfc44;
        errors       = 0;
        pred_count   = 0;
        dis_count    = 0;
        commit_count = 0;
        cur_test     = "reset";
        model_reset();
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        test_reset_state();
        test_in_order();
        test_out_of_order();
        test_same_dest();
        test_back_pressure();
        test_recycling();

        cur_test = "summary";
        if (dis_count != pred_count) report_mismatch("dispatched total", pred_count, dis_count);
        if (commit_count != pred_count) report_mismatch("committed total", pred_count, commit_count);
        $display("instructions committed: %0d, errors: %0d", commit_count, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu
    import sys_defs_pkg::*;
#(
    parameter int n      = 2,
    parameter int ib_sz  = 8,
    parameter int rob_sz = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    input  inst_packet_t [7:0]         in_insts,
    input  logic [3:0]                 num_input,
    input  cdb_packet_t                cdb_in,
    output commit_packet_t [n-1:0]     committed_insts,
    output logic [$clog2(ib_sz+1)-1:0] ib_open
);

    ////////////////////////////////////////////////////////////////////////////
    // pipeline wires
    ////////////////////////////////////////////////////////////////////////////

    inst_packet_t [n-1:0]         ib_insts;     // oldest n in the buffer
    decoded_packet_t [n-1:0]      dis_insts;    // renamed group into the rob
    logic [$clog2(n+1)-1:0]       num_dis;
    logic [$clog2(n+1)-1:0]       num_retired;
    logic [$clog2(n+1)-1:0]       rob_open;
    phys_reg_idx_t [n-1:0]        fl_regs;
    logic [$clog2(free_sz+1)-1:0] fl_count;
    reg_idx_t [n-1:0]             mt_r1;        // map table read indexes
    reg_idx_t [n-1:0]             mt_r2;
    reg_idx_t [n-1:0]             mt_dest;
    phys_reg_idx_t [n-1:0]        mt_t1;
    phys_reg_idx_t [n-1:0]        mt_t2;
    phys_reg_idx_t [n-1:0]        mt_t_old;
    reg_idx_t [n-1:0]             mt_wr_dest;
    phys_reg_idx_t [n-1:0]        mt_wr_t;
    phys_reg_idx_t [n-1:0]        freed_regs;   // t_old of retiring lanes

    // field selects only
    always_comb begin
        for (int i = 0; i < n; i++) begin
            mt_r1[i]      = ib_insts[i].reg1;
            mt_r2[i]      = ib_insts[i].reg2;
            mt_dest[i]    = ib_insts[i].dest_reg_idx;
            freed_regs[i] = committed_insts[i].t_old;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////////////////////

    inst_buffer #(.n(n), .ib_sz(ib_sz)) u_inst_buffer (
        .clock            (clock),
        .reset            (reset),
        .in_insts         (in_insts),
        .num_input        (num_input),
        .num_dispatch     (num_dis),
        .dispatched_insts (ib_insts),
        .open_entries     (ib_open)
    );

    dispatch #(.n(n)) u_dispatch (
        .ib_insts   (ib_insts),
        .rob_open   (rob_open),
        .fl_count   (fl_count),
        .fl_regs    (fl_regs),
        .mt_t1      (mt_t1),
        .mt_t2      (mt_t2),
        .mt_t_old   (mt_t_old),
        .num_dis    (num_dis),
        .dis_insts  (dis_insts),
        .mt_wr_dest (mt_wr_dest),
        .mt_wr_t    (mt_wr_t)
    );

    map_table #(.n(n)) u_map_table (
        .clock        (clock),
        .reset        (reset),
        .r1_idx       (mt_r1),
        .r2_idx       (mt_r2),
        .dest_reg_idx (mt_dest),
        .wr_dest      (mt_wr_dest),
        .wr_t         (mt_wr_t),
        .wr_num       (num_dis),
        .t1           (mt_t1),
        .t2           (mt_t2),
        .t_old        (mt_t_old)
    );

    free_list #(.n(n)) u_free_list (
        .clock  (clock),
        .reset  (reset),
        .rd_num (num_dis),      // pop at dispatch
        .wr_num (num_retired),  // push at retire
        .wr_reg (freed_regs),
        .rd_reg (fl_regs),
        .count  (fl_count)
    );

    rob #(.n(n), .rob_sz(rob_sz)) u_rob (
        .clock        (clock),
        .reset        (reset),
        .wr_data      (dis_insts),
        .num_accept   (num_dis),
        .cdb_in       (cdb_in),
        .retiring     (committed_insts),
        .num_retired  (num_retired),
        .open_entries (rob_open)
    );

endmodule

`default_nettype wire

// ==== rtl/rob.sv ====
`timescale 1ns/100ps
`default_nettype none

module rob
    import sys_defs_pkg::*;
#(
    parameter int n      = 2,
    parameter int rob_sz = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  decoded_packet_t [n-1:0]     wr_data,
    input  logic [$clog2(n+1)-1:0]      num_accept,
    input  cdb_packet_t                 cdb_in,
    output commit_packet_t [n-1:0]      retiring,
    output logic [$clog2(n+1)-1:0]      num_retired,
    output logic [$clog2(n+1)-1:0]      open_entries  // capped at n
);

    localparam int ptr_w = $clog2(rob_sz);

    typedef logic [ptr_w-1:0]            ptr_t;
    typedef logic [$clog2(rob_sz+1)-1:0] cnt_t;

    rob_entry_t        entries [rob_sz];
    ptr_t              head;
    ptr_t              tail;
    cnt_t              count;
    logic [n-1:0]      ret_ok;   // lane retires this cycle
    logic [rob_sz-1:0] cdb_hit;  // entry matched by the broadcast

    ////////////////////////////////////////////////////////////////////////////
    // retirement from the head
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rob_entry_t e;
        logic       run;
        run         = 1'b1;
        num_retired = '0;
        for (int i = 0; i < n; i++) begin
            e         = entries[(int'(head) + i) % rob_sz];
            ret_ok[i] = run && e.valid && e.complete;  // stops at first incomplete
            run       = ret_ok[i];
            retiring[i].valid        = ret_ok[i];
            retiring[i].dest_reg_idx = e.dest_reg_idx;
            retiring[i].t            = e.t;
            retiring[i].t_old        = e.t_old;
            if (ret_ok[i]) num_retired = num_retired + 1'b1;
        end
    end

    // room for dispatch counts this cycle's retirement
    always_comb begin
        int space;
        space        = rob_sz - int'(count) + int'(num_retired);
        open_entries = ($clog2(n+1))'((space > n) ? n : space);
    end

    always_comb begin
        for (int i = 0; i < rob_sz; i++) begin
            cdb_hit[i] = cdb_in.valid && entries[i].valid && (entries[i].t == cdb_in.t);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry updates
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rob_sz; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].complete <= 1'b0;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            for (int i = 0; i < rob_sz; i++) begin
                if (cdb_hit[i]) entries[i].complete <= 1'b1;
            end
            for (int i = 0; i < n; i++) begin
                if (ret_ok[i]) entries[(int'(head) + i) % rob_sz].valid <= 1'b0;
            end
            // new entries last so a slot freed this cycle may be reused
            for (int i = 0; i < n; i++) begin
                if (i < int'(num_accept)) begin
                    entries[(int'(tail) + i) % rob_sz].valid        <= 1'b1;
                    entries[(int'(tail) + i) % rob_sz].complete     <= 1'b0;
                    entries[(int'(tail) + i) % rob_sz].dest_reg_idx <= wr_data[i].dest_reg_idx;
                    entries[(int'(tail) + i) % rob_sz].t            <= wr_data[i].t;
                    entries[(int'(tail) + i) % rob_sz].t_old        <= wr_data[i].t_old;
                end
            end
            head  <= ptr_t'((int'(head) + int'(num_retired)) % rob_sz);
            tail  <= ptr_t'((int'(tail) + int'(num_accept)) % rob_sz);
            count <= cnt_t'(int'(count) + int'(num_accept) - int'(num_retired));
        end
    end

    // every broadcast tag belongs to an in-flight inst
    a_cdb_orphan : assert property (@(posedge clock) disable iff (reset)
        cdb_in.valid |-> (|cdb_hit))
        else $error("rob: cdb tag %0d matches no entry", cdb_in.t);

    a_rob_overflow : assert property (@(posedge clock) disable iff (reset)
        num_accept <= open_entries)
        else $error("rob: %0d accepted with %0d open", num_accept, open_entries);

endmodule

`default_nettype wire

// ==== rtl/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list
    import sys_defs_pkg::*;
#(
    parameter int n = 2
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [$clog2(n+1)-1:0]       rd_num,  // tags handed to dispatch
    input  logic [$clog2(n+1)-1:0]       wr_num,  // tags freed by retirement
    input  phys_reg_idx_t [n-1:0]        wr_reg,
    output phys_reg_idx_t [n-1:0]        rd_reg,
    output logic [$clog2(free_sz+1)-1:0] count
);

    localparam int ptr_w = $clog2(free_sz);

    typedef logic [ptr_w-1:0] ptr_t;

    phys_reg_idx_t entries [free_sz];
    ptr_t          head;
    ptr_t          tail;

    // head of the fifo seen by dispatch
    always_comb begin
        for (int i = 0; i < n; i++) begin
            rd_reg[i] = entries[(int'(head) + i) % free_sz];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < free_sz; i++) begin
                entries[i] <= phys_reg_idx_t'(arch_reg_sz + i);  // tags above the arch regs
            end
            head  <= '0;
            tail  <= '0;                                       // full so tail has wrapped
            count <= ($clog2(free_sz+1))'(free_sz);
        end else begin
            for (int i = 0; i < n; i++) begin
                if (i < int'(wr_num)) begin
                    entries[(int'(tail) + i) % free_sz] <= wr_reg[i];  // lane order
                end
            end
            head  <= ptr_t'((int'(head) + int'(rd_num)) % free_sz);
            tail  <= ptr_t'((int'(tail) + int'(wr_num)) % free_sz);
            count <= ($clog2(free_sz+1))'(int'(count) + int'(wr_num) - int'(rd_num));
        end
    end

    // dispatch may only take what is there
    a_fl_underflow : assert property (@(posedge clock) disable iff (reset)
        int'(rd_num) <= int'(count))
        else $error("free_list: %0d taken with %0d free", rd_num, count);

endmodule

`default_nettype wire

// ==== rtl/map_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module map_table
    import sys_defs_pkg::*;
#(
    parameter int n = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  reg_idx_t [n-1:0]       r1_idx,
    input  reg_idx_t [n-1:0]       r2_idx,
    input  reg_idx_t [n-1:0]       dest_reg_idx,  // read for t_old
    input  reg_idx_t [n-1:0]       wr_dest,
    input  phys_reg_idx_t [n-1:0]  wr_t,
    input  logic [$clog2(n+1)-1:0] wr_num,
    output phys_reg_idx_t [n-1:0]  t1,
    output phys_reg_idx_t [n-1:0]  t2,
    output phys_reg_idx_t [n-1:0]  t_old
);

    phys_reg_idx_t map [arch_reg_sz];  // arch reg -> current tag

    // 3n read ports see the map before this cycle's writes
    always_comb begin
        for (int i = 0; i < n; i++) begin
            t1[i]    = map[r1_idx[i]];
            t2[i]    = map[r2_idx[i]];
            t_old[i] = map[dest_reg_idx[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < arch_reg_sz; i++) begin
                map[i] <= phys_reg_idx_t'(i);  // identity mapping
            end
        end else begin
            for (int i = 0; i < n; i++) begin
                if (i < int'(wr_num)) map[wr_dest[i]] <= wr_t[i];  // later lane wins
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch
    import sys_defs_pkg::*;
#(
    parameter int n = 2
) (
    input  inst_packet_t [n-1:0]         ib_insts,
    input  logic [$clog2(n+1)-1:0]       rob_open,
    input  logic [$clog2(free_sz+1)-1:0] fl_count,
    input  phys_reg_idx_t [n-1:0]        fl_regs,    // n oldest free tags
    input  phys_reg_idx_t [n-1:0]        mt_t1,      // map table reads
    input  phys_reg_idx_t [n-1:0]        mt_t2,
    input  phys_reg_idx_t [n-1:0]        mt_t_old,
    output logic [$clog2(n+1)-1:0]       num_dis,
    output decoded_packet_t [n-1:0]      dis_insts,
    output reg_idx_t [n-1:0]             mt_wr_dest,
    output phys_reg_idx_t [n-1:0]        mt_wr_t
);

    ////////////////////////////////////////////////////////////////////////////
    // dispatch count
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        int   avail;
        logic gap;
        avail = 0;
        gap   = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (ib_insts[i].valid && !gap) avail++;  // leading valid lanes only
            else gap = 1'b1;
        end
        if (int'(rob_open) < avail) avail = int'(rob_open);
        if (int'(fl_count) < avail) avail = int'(fl_count);  // need a tag per lane
        num_dis = ($clog2(n+1))'(avail);
    end

    ////////////////////////////////////////////////////////////////////////////
    // renaming with in-group bypass
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < n; i++) begin
            dis_insts[i].valid        = (i < int'(num_dis));
            dis_insts[i].dest_reg_idx = ib_insts[i].dest_reg_idx;
            dis_insts[i].reg1         = ib_insts[i].reg1;
            dis_insts[i].reg2         = ib_insts[i].reg2;
            dis_insts[i].t            = fl_regs[i];
            dis_insts[i].t1           = mt_t1[i];
            dis_insts[i].t2           = mt_t2[i];
            dis_insts[i].t_old        = mt_t_old[i];
            // map table is a cycle behind for earlier lanes
            // ascending j so the youngest writer wins
            for (int j = 0; j < i; j++) begin
                if (ib_insts[j].dest_reg_idx == ib_insts[i].reg1) dis_insts[i].t1 = fl_regs[j];
                if (ib_insts[j].dest_reg_idx == ib_insts[i].reg2) dis_insts[i].t2 = fl_regs[j];
                if (ib_insts[j].dest_reg_idx == ib_insts[i].dest_reg_idx) begin
                    dis_insts[i].t_old = fl_regs[j];
                end
            end
            mt_wr_dest[i] = ib_insts[i].dest_reg_idx;  // map table keeps first num_dis
            mt_wr_t[i]    = fl_regs[i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inst_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_buffer
    import sys_defs_pkg::*;
#(
    parameter int n     = 2,
    parameter int ib_sz = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    input  inst_packet_t [7:0]         in_insts,
    input  logic [3:0]                 num_input,     // packets offered this cycle
    input  logic [$clog2(n+1)-1:0]     num_dispatch,  // packets taken by dispatch
    output inst_packet_t [n-1:0]       dispatched_insts,
    output logic [$clog2(ib_sz+1)-1:0] open_entries
);

    localparam int ptr_w = $clog2(ib_sz);

    typedef logic [ptr_w-1:0]           ptr_t;
    typedef logic [$clog2(ib_sz+1)-1:0] cnt_t;

    inst_packet_t entries [ib_sz];  // payload only
    ptr_t         head;             // oldest entry
    ptr_t         tail;             // next free slot
    cnt_t         count;

    assign open_entries = cnt_t'(ib_sz) - count;

    // oldest n go to dispatch
    always_comb begin
        for (int i = 0; i < n; i++) begin
            dispatched_insts[i]       = entries[(int'(head) + i) % ib_sz];
            dispatched_insts[i].valid = (i < int'(count));  // nothing past occupancy
        end
    end

    // first num_input packets land at the tail
    always_ff @(posedge clock) begin
        for (int i = 0; i < 8; i++) begin
            if (i < int'(num_input)) begin
                entries[(int'(tail) + i) % ib_sz] <= in_insts[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= ptr_t'((int'(head) + int'(num_dispatch)) % ib_sz);
            tail  <= ptr_t'((int'(tail) + int'(num_input)) % ib_sz);
            count <= cnt_t'(int'(count) + int'(num_input) - int'(num_dispatch));
        end
    end

    // sender has to respect the open count
    a_ib_overflow : assert property (@(posedge clock) disable iff (reset)
        int'(num_input) <= int'(open_entries))
        else $error("inst_buffer: %0d offered with %0d open", num_input, open_entries);

endmodule

`default_nettype wire

// ==== rtl/sys_defs_pkg.sv ====
`default_nettype none

package sys_defs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register file sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int arch_reg_sz = 8;                          // architectural regs
    localparam int phys_reg_sz = 16;                         // physical regs
    localparam int free_sz     = phys_reg_sz - arch_reg_sz;  // free list depth

    typedef logic [$clog2(arch_reg_sz)-1:0] reg_idx_t;       // arch index
    typedef logic [$clog2(phys_reg_sz)-1:0] phys_reg_idx_t;  // physical tag

    ////////////////////////////////////////////////////////////////////////////
    // packets between the blocks
    ////////////////////////////////////////////////////////////////////////////

    // one decoded instruction from outside
    typedef struct packed {
        logic     valid;
        reg_idx_t dest_reg_idx;
        reg_idx_t reg1;
        reg_idx_t reg2;
    } inst_packet_t;

    // renamed instruction leaving dispatch
    typedef struct packed {
        logic          valid;
        reg_idx_t      dest_reg_idx;
        reg_idx_t      reg1;
        reg_idx_t      reg2;
        phys_reg_idx_t t;      // new tag for dest
        phys_reg_idx_t t1;     // source tags
        phys_reg_idx_t t2;
        phys_reg_idx_t t_old;  // dest mapping before this inst
    } decoded_packet_t;

    // completion broadcast
    typedef struct packed {
        logic          valid;
        phys_reg_idx_t t;
    } cdb_packet_t;

    typedef struct packed {
        logic          valid;
        reg_idx_t      dest_reg_idx;
        phys_reg_idx_t t;
        phys_reg_idx_t t_old;  // goes back to the free list
    } commit_packet_t;

    typedef struct packed {
        logic          valid;
        logic          complete;
        reg_idx_t      dest_reg_idx;
        phys_reg_idx_t t;
        phys_reg_idx_t t_old;
    } rob_entry_t;

endpackage

`default_nettype wire
